/* source/ooo_pkg.sv */
package ooo_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Operand and result width
    localparam int DATA_BITS = 32;
    // Physical tag width
    localparam int TAG_BITS = 5;

    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [TAG_BITS-1:0]  tag_t;

    //////////////////////////////
    // Opcodes
    //////////////////////////////

    // MUL goes to the MULT bank, everything else to the ALU bank
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        MUL = 3'd5
    } opcode_e;

    //////////////////////////////
    // Packed structs
    //////////////////////////////

    // One source operand
    // A ready operand still matches its tag against the CDB result,
    // so a ready operand carries its producer tag or a tag not in flight
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        data_t value;
    } operand_t;

    // Reservation-station entry, also the dispatch payload
    typedef struct packed {
        logic     valid;
        opcode_e  op;
        tag_t     dest_tag;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    // Issue to execute, operands fully resolved
    typedef struct packed {
        logic    valid;
        opcode_e op;
        tag_t    dest_tag;
        data_t   value1;
        data_t   value2;
    } issue_t;

    // Broadcast, value unused for the early tag
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } cdb_t;

endpackage

/* source/rs_bank.sv */
`timescale 1ns/10ps

module rs_bank #(
    parameter int RS_SIZE = 4
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              alloc,
    input  ooo_pkg::rs_entry_t                alloc_entry,
    input  ooo_pkg::cdb_t                     early_tag,
    input  ooo_pkg::cdb_t                     cdb_out,
    input  logic                              clear,
    input  logic [$clog2(RS_SIZE)-1:0]        clear_idx,
    input  logic                              mispredict,
    output ooo_pkg::rs_entry_t [RS_SIZE-1:0]  entries,
    output logic                              full
);
    import ooo_pkg::*;

    // Per operand: woken by early tag, value arrives on next CDB
    logic [RS_SIZE-1:0][1:0] value_wait;

    logic [RS_SIZE-1:0]      valid_vec;
    logic [RS_SIZE-1:0]      free_slot;
    logic [RS_SIZE-1:0]      alloc_onehot;
    logic [RS_SIZE-1:0]      clear_onehot;

    // Snooped versions of stored entries and of the incoming one
    rs_entry_t [RS_SIZE-1:0] entry_snoop;
    logic [RS_SIZE-1:0][1:0] wait_snoop;
    rs_entry_t               alloc_snoop;
    logic [1:0]              alloc_wait;

    // Wakeup and capture for one operand
    function automatic operand_t snoop(input operand_t op, input logic wait_in,
                                       input cdb_t early, input cdb_t result,
                                       output logic wait_out);
        operand_t upd;
        upd      = op;
        wait_out = wait_in;
        // Result match: take value now
        if (result.valid && result.tag == op.tag && (!op.ready || wait_in)) begin
            upd.ready = 1'b1;
            upd.value = result.value;
            wait_out  = 1'b0;
        end else if (early.valid && early.tag == op.tag && !op.ready) begin
            // Early match: ready now, value one cycle later
            upd.ready = 1'b1;
            wait_out  = 1'b1;
        end
        return upd;
    endfunction

    //////////////////////////////
    // Slot selection
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            valid_vec[i] = entries[i].valid;
        end
        free_slot = ~valid_vec;
        // Lowest free slot, isolated as one-hot
        alloc_onehot = alloc ? (free_slot & (~free_slot + 1'b1)) : '0;
        clear_onehot = clear ? (RS_SIZE'(1) << clear_idx) : '0;
    end

    assign full = &valid_vec;

    //////////////////////////////
    // Operand snooping
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            entry_snoop[i]      = entries[i];
            entry_snoop[i].src1 = snoop(entries[i].src1, value_wait[i][0],
                                        early_tag, cdb_out, wait_snoop[i][0]);
            entry_snoop[i].src2 = snoop(entries[i].src2, value_wait[i][1],
                                        early_tag, cdb_out, wait_snoop[i][1]);
        end
        // Incoming entry sees the same broadcasts
        alloc_snoop       = alloc_entry;
        alloc_snoop.valid = 1'b1;
        alloc_snoop.src1  = snoop(alloc_entry.src1, 1'b0, early_tag, cdb_out, alloc_wait[0]);
        alloc_snoop.src2  = snoop(alloc_entry.src2, 1'b0, early_tag, cdb_out, alloc_wait[1]);
    end

    //////////////////////////////
    // Entry storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || mispredict) begin
            // Flush drops every entry
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].valid <= 1'b0;
                value_wait[i]    <= 2'b00;
            end
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (alloc_onehot[i]) begin
                    entries[i]    <= alloc_snoop;
                    value_wait[i] <= alloc_wait;
                end else if (clear_onehot[i]) begin
                    // Issued this cycle
                    entries[i].valid <= 1'b0;
                    value_wait[i]    <= 2'b00;
                end else if (entries[i].valid) begin
                    entries[i]    <= entry_snoop[i];
                    value_wait[i] <= wait_snoop[i];
                end
            end
        end
    end

endmodule

/* source/issue_select.sv */
`timescale 1ns/10ps

module issue_select #(
    parameter int ALU_RS_SIZE  = 6,
    parameter int MULT_RS_SIZE = 2
) (
    input  ooo_pkg::rs_entry_t [ALU_RS_SIZE-1:0]  alu_entries,
    input  ooo_pkg::rs_entry_t [MULT_RS_SIZE-1:0] mult_entries,
    input  ooo_pkg::cdb_t                         cdb_out,
    input  logic [1:0]                            grant,
    input  logic                                  mispredict,
    output logic [1:0]                            request,
    output logic                                  alu_clear,
    output logic                                  mult_clear,
    output logic [$clog2(ALU_RS_SIZE)-1:0]        alu_clear_idx,
    output logic [$clog2(MULT_RS_SIZE)-1:0]       mult_clear_idx,
    output ooo_pkg::issue_t                       issue
);
    import ooo_pkg::*;

    localparam int MAX_SIZE      = (ALU_RS_SIZE > MULT_RS_SIZE) ? ALU_RS_SIZE : MULT_RS_SIZE;
    localparam int ALU_IDX_BITS  = $clog2(ALU_RS_SIZE);
    localparam int MULT_IDX_BITS = $clog2(MULT_RS_SIZE);

    logic [ALU_RS_SIZE-1:0]   alu_ready;
    logic [MULT_RS_SIZE-1:0]  mult_ready;
    logic [ALU_IDX_BITS-1:0]  alu_pick;
    logic [MULT_IDX_BITS-1:0] mult_pick;
    rs_entry_t                chosen;

    // Both operands known
    function automatic logic entry_ready(input rs_entry_t e);
        return e.valid && e.src1.ready && e.src2.ready;
    endfunction

    // Priority encoder, lowest index wins
    function automatic int lowest_set(input logic [MAX_SIZE-1:0] vec);
        int idx;
        idx = 0;
        for (int i = MAX_SIZE - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Value still in flight on the CDB this cycle
    function automatic data_t resolve(input operand_t op, input cdb_t cdb);
        if (cdb.valid && cdb.tag == op.tag) begin
            return cdb.value;
        end
        return op.value;
    endfunction

    //////////////////////////////
    // Ready scan and requests
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < ALU_RS_SIZE; i++) begin
            alu_ready[i] = entry_ready(alu_entries[i]);
        end
        for (int i = 0; i < MULT_RS_SIZE; i++) begin
            mult_ready[i] = entry_ready(mult_entries[i]);
        end
        alu_pick  = ALU_IDX_BITS'(lowest_set(MAX_SIZE'(alu_ready)));
        mult_pick = MULT_IDX_BITS'(lowest_set(MAX_SIZE'(mult_ready)));
        // Bit 0 ALU, bit 1 MULT; silent during flush
        request = {|mult_ready, |alu_ready} & {2{~mispredict}};
    end

    //////////////////////////////
    // Granted bank issues
    //////////////////////////////

    always_comb begin
        alu_clear      = grant[0] && request[0];
        mult_clear     = grant[1] && request[1];
        alu_clear_idx  = alu_pick;
        mult_clear_idx = mult_pick;
        chosen = mult_clear ? mult_entries[mult_pick] : alu_entries[alu_pick];
        issue  = '0;
        if (alu_clear || mult_clear) begin
            issue.valid    = 1'b1;
            issue.op       = chosen.op;
            issue.dest_tag = chosen.dest_tag;
            issue.value1   = resolve(chosen.src1, cdb_out);
            issue.value2   = resolve(chosen.src2, cdb_out);
        end
    end

endmodule

/* source/cdb_arbiter.sv */
`timescale 1ns/10ps

module cdb_arbiter (
    input  logic            clock,
    input  logic            reset,
    input  logic [1:0]      request,
    input  ooo_pkg::issue_t issue,
    output logic [1:0]      grant,
    output ooo_pkg::cdb_t   early_tag
);
    import ooo_pkg::*;

    // MULT bank held the slot most recently
    logic last_mult;

    //////////////////////////////
    // Round-robin grant
    //////////////////////////////

    always_comb begin
        case (request)
            2'b01: grant = 2'b01;
            2'b10: grant = 2'b10;
            // Contention goes to the bank not served last
            2'b11: grant = last_mult ? 2'b01 : 2'b10;
            default: grant = 2'b00;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_mult <= 1'b0;
        end else if (|grant) begin
            last_mult <= grant[1];
        end
    end

    //////////////////////////////
    // Early tag
    //////////////////////////////

    // Issued tag announced one cycle ahead of its result
    assign early_tag.valid = issue.valid;
    assign early_tag.tag   = issue.dest_tag;
    assign early_tag.value = '0;

endmodule

/* source/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit (
    input  logic            clock,
    input  logic            reset,
    input  ooo_pkg::issue_t issue,
    output ooo_pkg::cdb_t   cdb_out
);
    import ooo_pkg::*;

    data_t result;

    //////////////////////////////
    // Functional unit
    //////////////////////////////

    always_comb begin
        case (issue.op)
            ADD: result = issue.value1 + issue.value2;
            SUB: result = issue.value1 - issue.value2;
            AND: result = issue.value1 & issue.value2;
            OR:  result = issue.value1 | issue.value2;
            XOR: result = issue.value1 ^ issue.value2;
            // Low half of the product
            MUL: result = issue.value1 * issue.value2;
            default: result = '0;
        endcase
    end

    //////////////////////////////
    // Result register onto CDB
    //////////////////////////////

    always_ff @(posedge clock) begin
        cdb_out.tag   <= issue.dest_tag;
        cdb_out.value <= result;
        if (reset) begin
            cdb_out.valid <= 1'b0;
        end else begin
            cdb_out.valid <= issue.valid;
        end
    end

endmodule

/* source/ooo_core.sv */
`timescale 1ns/10ps

module ooo_core #(
    parameter int ALU_RS_SIZE  = 6,
    parameter int MULT_RS_SIZE = 2
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_valid,
    input  ooo_pkg::rs_entry_t dispatch,
    input  logic               mispredict,
    output logic               alu_full,
    output logic               mult_full,
    output ooo_pkg::cdb_t      cdb_out
);
    import ooo_pkg::*;

    // Bank contents
    rs_entry_t [ALU_RS_SIZE-1:0]  alu_entries;
    rs_entry_t [MULT_RS_SIZE-1:0] mult_entries;

    // Dispatch steering by opcode
    logic alu_alloc;
    logic mult_alloc;

    // Issue to bank clears
    logic                            alu_clear;
    logic                            mult_clear;
    logic [$clog2(ALU_RS_SIZE)-1:0]  alu_clear_idx;
    logic [$clog2(MULT_RS_SIZE)-1:0] mult_clear_idx;

    // Arbitration and broadcast
    logic [1:0] request;
    logic [1:0] grant;
    issue_t     issue;
    cdb_t       early_tag;

    assign alu_alloc  = dispatch_valid && (dispatch.op != MUL);
    assign mult_alloc = dispatch_valid && (dispatch.op == MUL);

    //////////////////////////////
    // Reservation stations
    //////////////////////////////

    rs_bank #(.RS_SIZE(ALU_RS_SIZE)) alu_rs (
        .clock      (clock),
        .reset      (reset),
        .alloc      (alu_alloc),
        .alloc_entry(dispatch),
        .early_tag  (early_tag),
        .cdb_out    (cdb_out),
        .clear      (alu_clear),
        .clear_idx  (alu_clear_idx),
        .mispredict (mispredict),
        .entries    (alu_entries),
        .full       (alu_full)
    );

    rs_bank #(.RS_SIZE(MULT_RS_SIZE)) mult_rs (
        .clock      (clock),
        .reset      (reset),
        .alloc      (mult_alloc),
        .alloc_entry(dispatch),
        .early_tag  (early_tag),
        .cdb_out    (cdb_out),
        .clear      (mult_clear),
        .clear_idx  (mult_clear_idx),
        .mispredict (mispredict),
        .entries    (mult_entries),
        .full       (mult_full)
    );

    //////////////////////////////
    // Issue, CDB and execute
    //////////////////////////////

    issue_select #(
        .ALU_RS_SIZE (ALU_RS_SIZE),
        .MULT_RS_SIZE(MULT_RS_SIZE)
    ) issue_sel (
        .alu_entries   (alu_entries),
        .mult_entries  (mult_entries),
        .cdb_out       (cdb_out),
        .grant         (grant),
        .mispredict    (mispredict),
        .request       (request),
        .alu_clear     (alu_clear),
        .mult_clear    (mult_clear),
        .alu_clear_idx (alu_clear_idx),
        .mult_clear_idx(mult_clear_idx),
        .issue         (issue)
    );

    cdb_arbiter cdb_arb (
        .clock    (clock),
        .reset    (reset),
        .request  (request),
        .issue    (issue),
        .grant    (grant),
        .early_tag(early_tag)
    );

    // Single registered stage, drives the CDB
    exec_unit exec (
        .clock  (clock),
        .reset  (reset),
        .issue  (issue),
        .cdb_out(cdb_out)
    );

endmodule

/* verification/ooo_checker.sv */
`timescale 1ns/10ps

module ooo_checker #(
    parameter int TAGS      = 32,
    parameter int ALU_SIZE  = 6,
    parameter int MULT_SIZE = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  ooo_pkg::cdb_t        cdb_out,
    input  logic                 alu_full,
    input  logic                 mult_full,
    input  logic [1:0]           tag_state [TAGS],
    input  logic                 exp_known [TAGS],
    input  ooo_pkg::data_t       exp_value [TAGS],
    input  int                   bcast_cnt [TAGS],
    input  int                   alu_occ,
    input  int                   mult_occ,
    output int                   value_errors,
    output int                   protocol_errors
);
    import ooo_pkg::*;

    // Tag states kept by the model
    localparam logic [1:0] FREE = 2'd0;
    localparam logic [1:0] DEAD = 2'd3;

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
    end

    //////////////////////////////
    // CDB result check
    //////////////////////////////

    // Sampled at the rising edge, values held since the previous one
    always @(posedge clock) begin
        if (!reset && cdb_out.valid) begin
            if (tag_state[cdb_out.tag] == FREE) begin
                $display("tag %0d broadcast but never dispatched", cdb_out.tag);
                protocol_errors++;
            end else if (tag_state[cdb_out.tag] == DEAD) begin
                $display("tag %0d broadcast after being flushed", cdb_out.tag);
                protocol_errors++;
            end else if (bcast_cnt[cdb_out.tag] != 1) begin
                $display("tag %0d broadcast more than once", cdb_out.tag);
                protocol_errors++;
            end else if (!exp_known[cdb_out.tag]) begin
                $display("tag %0d broadcast before its sources", cdb_out.tag);
                protocol_errors++;
            end else if (cdb_out.value !== exp_value[cdb_out.tag]) begin
                $display("error cdb_out.value tag %h: got %h expected %h",
                         cdb_out.tag, cdb_out.value, exp_value[cdb_out.tag]);
                value_errors++;
            end
        end
    end

    //////////////////////////////
    // Full flags
    //////////////////////////////

    always @(posedge clock) begin
        if (!reset) begin
            if (alu_full !== (alu_occ == ALU_SIZE)) begin
                $display("error alu_full: got %h expected %h", alu_full, alu_occ == ALU_SIZE);
                value_errors++;
            end
            if (mult_full !== (mult_occ == MULT_SIZE)) begin
                $display("error mult_full: got %h expected %h",
                         mult_full, mult_occ == MULT_SIZE);
                value_errors++;
            end
        end
    end

endmodule

/* verification/ooo_props.sv */
`timescale 1ns/10ps

module ooo_props (
    input logic          clock,
    input logic          reset,
    input logic [1:0]    request,
    input logic [1:0]    grant,
    input ooo_pkg::cdb_t early_tag,
    input ooo_pkg::cdb_t cdb_out,
    input logic          alu_alloc,
    input logic          alu_full,
    input logic          mult_alloc,
    input logic          mult_full
);
    import ooo_pkg::*;

    // Under contention the slot goes to the other bank than last time
    grant_round_robin: assert property (@(posedge clock) disable iff (reset)
        (request == 2'b11 && $past(grant) != 2'b00) |-> (grant == ~$past(grant)))
        else $error("CDB grant did not alternate under contention: %b", grant);

    // Early tag is followed by the result with the same tag
    early_then_result: assert property (@(posedge clock) disable iff (reset)
        early_tag.valid |=> (cdb_out.valid && cdb_out.tag == $past(early_tag.tag)))
        else $error("early tag not followed by matching CDB result");

    // A full bank is never allocated into
    alu_no_overflow: assert property (@(posedge clock) disable iff (reset)
        alu_alloc |-> !alu_full)
        else $error("alloc into full ALU bank");

    mult_no_overflow: assert property (@(posedge clock) disable iff (reset)
        mult_alloc |-> !mult_full)
        else $error("alloc into full MULT bank");

endmodule

bind ooo_core ooo_props props (
    .clock     (clock),
    .reset     (reset),
    .request   (request),
    .grant     (grant),
    .early_tag (early_tag),
    .cdb_out   (cdb_out),
    .alu_alloc (alu_alloc),
    .alu_full  (alu_full),
    .mult_alloc(mult_alloc),
    .mult_full (mult_full)
);

/* verification/ooo_tb.sv */
`timescale 1ns/10ps

module ooo_tb;
    import ooo_pkg::*;

    localparam int TAGS          = 32;
    localparam int ALU_SIZE      = 6;
    localparam int MULT_SIZE     = 2;
    localparam int RANDOM_CYCLES = 600;
    localparam int CHAIN_LEN     = 4;

    // Tag states
    localparam logic [1:0] FREE    = 2'd0;
    localparam logic [1:0] PENDING = 2'd1;
    localparam logic [1:0] DONE    = 2'd2;
    localparam logic [1:0] DEAD    = 2'd3;

    logic      clock;
    logic      reset;
    logic      dispatch_valid;
    rs_entry_t dispatch;
    logic      mispredict;
    logic      alu_full;
    logic      mult_full;
    cdb_t      cdb_out;

    integer seed = 32'h931;

    // Model state per tag
    logic [1:0] tag_state [TAGS];
    logic       exp_known [TAGS];
    data_t      exp_value [TAGS];
    int         bcast_cnt [TAGS];
    int         bcast_cycle [TAGS];
    int         age [TAGS];
    opcode_e    op_of [TAGS];
    logic [1:0] src_wait [TAGS];
    tag_t       src_tag [TAGS][2];
    data_t      src_val [TAGS][2];

    int   alu_occ;
    int   mult_occ;
    int   alu_held;
    int   mult_held;
    int   cycle;
    int   chain_errors;
    int   value_errors;
    int   protocol_errors;
    tag_t chain [CHAIN_LEN];

    ooo_core #(.ALU_RS_SIZE(ALU_SIZE), .MULT_RS_SIZE(MULT_SIZE)) DUT (
        .clock         (clock),
        .reset         (reset),
        .dispatch_valid(dispatch_valid),
        .dispatch      (dispatch),
        .mispredict    (mispredict),
        .alu_full      (alu_full),
        .mult_full     (mult_full),
        .cdb_out       (cdb_out)
    );

    ooo_checker #(.TAGS(TAGS), .ALU_SIZE(ALU_SIZE), .MULT_SIZE(MULT_SIZE)) monitor (
        .clock(clock), .reset(reset), .cdb_out(cdb_out),
        .alu_full(alu_full), .mult_full(mult_full),
        .tag_state(tag_state), .exp_known(exp_known), .exp_value(exp_value),
        .bcast_cnt(bcast_cnt), .alu_occ(alu_held), .mult_occ(mult_held),
        .value_errors(value_errors), .protocol_errors(protocol_errors)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    //////////////////////////////
    // Model
    //////////////////////////////

    // Execute rules: 32-bit ALU ops, low half of the product
    function automatic data_t model_result(input opcode_e op, input data_t a, input data_t b);
        case (op)
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            default: return data_t'(64'(a) * 64'(b));
        endcase
    endfunction

    // Random tag in a given state, tag 0 means none (tag 0 is never dispatched)
    function automatic tag_t pick_tag(input logic [1:0] state);
        int start;
        start = $unsigned($random(seed)) % (TAGS - 1);
        for (int i = 0; i < TAGS - 1; i++) begin
            if (tag_state[1 + (start + i) % (TAGS - 1)] == state) begin
                return tag_t'(1 + (start + i) % (TAGS - 1));
            end
        end
        return '0;
    endfunction

    // A waiting entry still carries this tag in one of its operands
    function automatic logic tag_in_use(input tag_t t);
        for (int c = 0; c < TAGS; c++) begin
            if (tag_state[c] == PENDING && (src_tag[c][0] == t || src_tag[c][1] == t)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Instructions per bank that are dispatched and not yet broadcast
    always @(posedge clock) begin
        if (reset || mispredict) begin
            alu_occ  <= 0;
            mult_occ <= 0;
        end else begin
            alu_occ <= alu_occ + int'(dispatch_valid && dispatch.op != MUL)
                       - int'(cdb_out.valid && op_of[cdb_out.tag] != MUL);
            mult_occ <= mult_occ + int'(dispatch_valid && dispatch.op == MUL)
                        - int'(cdb_out.valid && op_of[cdb_out.tag] == MUL);
        end
    end

    // Entries still held by each bank
    // The instruction on the CDB left its bank one edge earlier
    assign alu_held  = alu_occ - int'(cdb_out.valid && op_of[cdb_out.tag] != MUL);
    assign mult_held = mult_occ - int'(cdb_out.valid && op_of[cdb_out.tag] == MUL);

    // Falling edge: absorb the current broadcast, then release inputs
    task automatic step();
        tag_t t;
        @(negedge clock);
        cycle++;
        dispatch_valid = 1'b0;
        mispredict     = 1'b0;
        for (int i = 0; i < TAGS; i++) begin
            if (tag_state[i] == DONE || tag_state[i] == DEAD) begin
                age[i]++;
                // Recycle once the checker has seen it and no waiting entry holds the tag
                if (age[i] >= 2 && !tag_in_use(tag_t'(i))) tag_state[i] = FREE;
            end
        end
        if (cdb_out.valid) begin
            t = cdb_out.tag;
            bcast_cnt[t]++;
            bcast_cycle[t] = cycle;
            if (tag_state[t] == PENDING) begin
                tag_state[t] = DONE;
                age[t]       = 0;
                // Wake consumers with the model value
                for (int c = 0; c < TAGS; c++) begin
                    for (int s = 0; s < 2; s++) begin
                        if (tag_state[c] == PENDING && src_wait[c][s] && src_tag[c][s] == t) begin
                            src_val[c][s]  = exp_value[t];
                            src_wait[c][s] = 1'b0;
                        end
                    end
                    if (tag_state[c] == PENDING && src_wait[c] == 2'b00 && !exp_known[c]) begin
                        exp_value[c] = model_result(op_of[c], src_val[c][0], src_val[c][1]);
                        exp_known[c] = 1'b1;
                    end
                end
            end
        end
    endtask

    // Source tag 0 is an immediate, a done tag is a ready value, else pending
    task automatic drive_entry(input opcode_e op, input tag_t dest, input tag_t s1, input tag_t s2);
        operand_t opnd [2];
        tag_t     src [2];
        src[0] = s1;
        src[1] = s2;
        for (int s = 0; s < 2; s++) begin
            opnd[s].tag   = src[s];
            opnd[s].ready = 1'b1;
            if (src[s] == 0) begin
                opnd[s].value = $random(seed);
            end else if (tag_state[src[s]] == DONE) begin
                opnd[s].tag   = '0;
                opnd[s].value = exp_value[src[s]];
            end else begin
                opnd[s].ready = 1'b0;
                opnd[s].value = '0;
            end
            src_tag[dest][s]  = opnd[s].tag;
            src_val[dest][s]  = opnd[s].value;
            src_wait[dest][s] = !opnd[s].ready;
        end
        tag_state[dest] = PENDING;
        op_of[dest]     = op;
        bcast_cnt[dest] = 0;
        exp_known[dest] = opnd[0].ready && opnd[1].ready;
        exp_value[dest] = model_result(op, opnd[0].value, opnd[1].value);
        dispatch       = '{valid: 1'b1, op: op, dest_tag: dest, src1: opnd[0], src2: opnd[1]};
        dispatch_valid = 1'b1;
    endtask

    task automatic dispatch_random();
        logic    is_mul;
        opcode_e op;
        tag_t    dest;
        tag_t    s [2];
        is_mul = ($unsigned($random(seed)) % 4) == 0;
        op     = is_mul ? MUL : opcode_e'($unsigned($random(seed)) % 5);
        dest   = pick_tag(FREE);
        if ((is_mul ? mult_held >= MULT_SIZE : alu_held >= ALU_SIZE) || dest == 0) begin
            return;
        end
        for (int i = 0; i < 2; i++) begin
            case ($unsigned($random(seed)) % 3)
                0: s[i] = '0;
                1: s[i] = pick_tag(DONE);
                default: s[i] = pick_tag(PENDING);
            endcase
        end
        drive_entry(op, dest, s[0], s[1]);
    endtask

    // Wait until nothing is in flight
    task automatic drain();
        int busy;
        do begin
            step();
            busy = 0;
            for (int i = 0; i < TAGS; i++) begin
                if (tag_state[i] == PENDING) busy++;
            end
        end while (busy != 0);
        repeat (3) step();
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        mispredict     = 1'b0;
        cycle          = 0;
        chain_errors   = 0;
        for (int i = 0; i < TAGS; i++) begin
            tag_state[i] = FREE;
            exp_known[i] = 1'b0;
            exp_value[i] = '0;
            bcast_cnt[i] = 0;
            age[i]       = 0;
            op_of[i]     = ADD;
            src_wait[i]  = 2'b00;
        end
        repeat (5) @(negedge clock);
        reset = 1'b0;

        // Random traffic with rare flushes
        repeat (RANDOM_CYCLES) begin
            step();
            if ($unsigned($random(seed)) % 40 == 0) begin
                mispredict = 1'b1;
                for (int i = 0; i < TAGS; i++) begin
                    if (tag_state[i] == PENDING) begin
                        tag_state[i] = DEAD;
                        age[i]       = 0;
                    end
                end
            end else begin
                dispatch_random();
            end
        end
        drain();

        // Dependent ALU chain, one broadcast per cycle
        for (int k = 0; k < CHAIN_LEN; k++) begin
            step();
            chain[k] = pick_tag(FREE);
            drive_entry(ADD, chain[k], (k == 0) ? tag_t'(0) : chain[k-1], '0);
        end
        drain();
        for (int k = 1; k < CHAIN_LEN; k++) begin
            if (bcast_cycle[chain[k]] != bcast_cycle[chain[k-1]] + 1) begin
                $display("chain tag %0d did not broadcast right after tag %0d",
                         chain[k], chain[k-1]);
                chain_errors++;
            end
        end

        $display("errors: value %0d, protocol %0d, chain %0d",
                 value_errors, protocol_errors, chain_errors);
        if (value_errors + protocol_errors + chain_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the random phase plus drain margin
    initial begin
        #((RANDOM_CYCLES + 400) * 100);
        $display("watchdog expired, simulation did not finish");
        $display("TB FAILED");
        $finish;
    end

endmodule

/* build.f */
source/ooo_pkg.sv
source/rs_bank.sv
source/issue_select.sv
source/cdb_arbiter.sv
source/exec_unit.sv
source/ooo_core.sv
verification/ooo_checker.sv
verification/ooo_props.sv
verification/ooo_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the scheduling core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ooo_tb \
    -f build.f -o ooo_sim > build.log 2>&1 \
    && ./obj_dir/ooo_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "TB PASSED" sim.log && echo "run ok" || { echo "run failed, see build.log and sim.log"; exit 1; }
